// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int queue_depth = 4;
  localparam int qptr_w = $clog2(queue_depth);
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  // addi x0, x0, 0
  localparam logic [xlen-1:0] bubble = 32'h0000_0013;

  // major opcodes
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] op_fence  = 7'b0001111;

  // privileged words, matched in full
  localparam logic [xlen-1:0] ecall_word  = 32'h0000_0073;
  localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;
  localparam logic [xlen-1:0] mret_word   = 32'h3020_0073;
  localparam logic [11:0]     mstatus_addr = 12'h300;
  // mie and mpie bits flipped by mret
  localparam logic [xlen-1:0] mret_mask = 32'h0000_0088;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_srl, alu_sra, alu_sll, alu_slt,
    alu_sltu, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu, alu_bit_c, alu_ill
  } alu_cmd_t;

  typedef enum logic [3:0] {
    mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_sb, mem_sh, mem_sw, mem_none
  } mem_access_t;

  typedef enum logic [2:0] {
    ri_type_lui, load, jump, zicsr, wb_mret, wb_none
  } wb_sel_t;

  typedef enum logic [1:0] {
    pc_next, pc_branch, pc_mret
  } pc_sel_t;

  typedef struct packed {
    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [12:0] imm_b;
    logic [31:0] imm_u;
    logic [20:0] imm_j;
  } instr_field_t;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
  } fetch_entry_t;

  typedef struct packed {
    alu_cmd_t        alu_cmd;
    mem_access_t     access;
    wb_sel_t         wb_sel;
    pc_sel_t         pc_sel;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [4:0]      rd;
    logic [11:0]     csr_addr;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] pc_target;
    logic            is_jump;
    logic            illegal;
    logic            env_call;
    logic            break_point;
    logic            mret;
    logic            csr;
  } decoded_t;

endpackage

`default_nettype wire

// ==== logic/req_ack_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface req_ack_if
  import core_pkg::*;
();
  logic         req;
  logic         ack;
  // held stable by the source while req is high
  fetch_entry_t entry;

  modport source (
    output req,
    output entry,
    input  ack
  );

  modport sink (
    input  req,
    input  entry,
    output ack
  );
endinterface

`default_nettype wire

// ==== logic/fetch_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_port
  import core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            in_req,
  output logic                 in_ack,
  input  wire logic [xlen-1:0] in_instr,
  req_ack_if.source            push
);
  typedef enum logic [1:0] {
    st_idle,
    st_push,
    st_done
  } state_t;

  state_t          state;
  logic [xlen-1:0] pc;
  logic            start;

  // new word upstream and the queue side back at rest
  assign start = (state == st_idle) && in_req && !push.ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      pc       <= reset_pc;
      push.req <= 1'b0;
      in_ack   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            push.req <= 1'b1;
            state    <= st_push;
          end
        end
        st_push: begin
          // queue took it, so upstream may go
          if (push.ack) begin
            push.req <= 1'b0;
            in_ack   <= 1'b1;
            pc       <= pc + 32'd4;
            state    <= st_done;
          end
        end
        st_done: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      push.entry.instr <= in_instr;
      push.entry.pc    <= pc;
    end
  end
endmodule

`default_nettype wire

// ==== logic/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
  import core_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst_n,
  req_ack_if.sink   push,
  req_ack_if.source pop
);
  fetch_entry_t      mem [queue_depth];
  logic [qptr_w-1:0] wr_ptr;
  logic [qptr_w-1:0] rd_ptr;
  logic [qptr_w:0]   count;
  logic              full;
  logic              wr_en;
  logic              rd_en;

  assign full  = (count == (qptr_w + 1)'(queue_depth));
  // a push is taken only when a slot is free
  assign wr_en = push.req && !push.ack && !full;
  // head leaves once the consumer acknowledges
  assign rd_en = pop.req && pop.ack;

  assign pop.entry = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      push.ack <= 1'b0;
      pop.req  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr   <= (wr_ptr == qptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
        push.ack <= 1'b1;
      end else if (push.ack && !push.req) begin
        push.ack <= 1'b0;
      end

      if (rd_en) begin
        rd_ptr  <= (rd_ptr == qptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
        pop.req <= 1'b0;
      end else if (!pop.req && !pop.ack && count != '0) begin
        // previous pop fully closed, offer the next head
        pop.req <= 1'b1;
      end

      count <= count + (qptr_w + 1)'(wr_en) - (qptr_w + 1)'(rd_en);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push.entry;
    end
  end

  // a full buffer never acknowledges a new push
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n) full |=> !$rose(push.ack)
  );

  a_pop_stable: assert property (
    @(posedge clk) disable iff (!rst_n) (pop.req && !$rose(pop.req)) |-> $stable(pop.entry)
  );

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(push.ack) |-> $past(push.req)
  );
endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import core_pkg::*;
(
  input  wire logic [xlen-1:0] instr,
  input  wire logic            valid,
  input  wire logic [xlen-1:0] pc,
  input  wire logic [xlen-1:0] rs1_data,
  input  wire logic [xlen-1:0] rs2_data,
  input  wire logic [xlen-1:0] csr_rdata,
  output decoded_t             dec,
  output logic [4:0]           rs1_addr,
  output logic [4:0]           rs2_addr
);
  logic [xlen-1:0] word;
  instr_field_t    f;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] uimm;

  // no entry held decodes as a nop
  assign word = valid ? instr : bubble;

  assign f.opcode = word[6:0];
  assign f.rd     = word[11:7];
  assign f.funct3 = word[14:12];
  assign f.rs1    = word[19:15];
  assign f.rs2    = word[24:20];
  assign f.funct7 = word[31:25];
  assign f.imm_i  = word[31:20];
  assign f.imm_s  = {word[31:25], word[11:7]};
  assign f.imm_b  = {word[31], word[7], word[30:25], word[11:8], 1'b0};
  assign f.imm_u  = {word[31:12], 12'h000};
  assign f.imm_j  = {word[31], word[19:12], word[20], word[30:21], 1'b0};

  assign imm_i = xlen'(signed'(f.imm_i));
  assign imm_s = xlen'(signed'(f.imm_s));
  assign imm_b = xlen'(signed'(f.imm_b));
  assign imm_j = xlen'(signed'(f.imm_j));
  // csr immediate forms reuse the rs1 field, zero extended
  assign uimm  = xlen'(f.rs1);

  assign rs1_addr = f.rs1;
  assign rs2_addr = f.rs2;

  always_comb begin
    dec           = '0;
    dec.alu_cmd   = alu_ill;
    dec.access    = mem_none;
    dec.wb_sel    = wb_none;
    dec.pc_sel    = pc_next;
    dec.rd        = f.rd;
    dec.pc_plus_4 = pc + 32'd4;
    case (f.opcode)
      op_r: begin
        dec.op1    = rs1_data;
        dec.op2    = rs2_data;
        dec.wb_sel = ri_type_lui;
        case ({f.funct7, f.funct3})
          10'b0000000_000: dec.alu_cmd = alu_add;
          10'b0100000_000: dec.alu_cmd = alu_sub;
          10'b0000000_001: dec.alu_cmd = alu_sll;
          10'b0000000_010: dec.alu_cmd = alu_slt;
          10'b0000000_011: dec.alu_cmd = alu_sltu;
          10'b0000000_100: dec.alu_cmd = alu_xor;
          10'b0000000_101: dec.alu_cmd = alu_srl;
          10'b0100000_101: dec.alu_cmd = alu_sra;
          10'b0000000_110: dec.alu_cmd = alu_or;
          10'b0000000_111: dec.alu_cmd = alu_and;
          default: ;
        endcase
      end
      op_imm: begin
        dec.op1    = rs1_data;
        dec.op2    = imm_i;
        dec.wb_sel = ri_type_lui;
        case (f.funct3)
          3'b000: dec.alu_cmd = alu_add;
          3'b010: dec.alu_cmd = alu_slt;
          3'b011: dec.alu_cmd = alu_sltu;
          3'b100: dec.alu_cmd = alu_xor;
          3'b110: dec.alu_cmd = alu_or;
          3'b111: dec.alu_cmd = alu_and;
          // shifts keep funct7 as a function code
          3'b001: if (f.funct7 == 7'b0000000) dec.alu_cmd = alu_sll;
          default: begin
            if (f.funct7 == 7'b0000000) begin
              dec.alu_cmd = alu_srl;
            end else if (f.funct7 == 7'b0100000) begin
              dec.alu_cmd = alu_sra;
            end
          end
        endcase
      end
      op_load: begin
        dec.op1     = rs1_data;
        dec.op2     = imm_i;
        dec.wb_sel  = load;
        dec.alu_cmd = alu_add;
        case (f.funct3)
          3'b000: dec.access = mem_lb;
          3'b001: dec.access = mem_lh;
          3'b010: dec.access = mem_lw;
          3'b100: dec.access = mem_lbu;
          3'b101: dec.access = mem_lhu;
          default: dec.alu_cmd = alu_ill;
        endcase
      end
      op_store: begin
        dec.op1     = rs1_data;
        dec.op2     = imm_s;
        dec.alu_cmd = alu_add;
        case (f.funct3)
          3'b000: dec.access = mem_sb;
          3'b001: dec.access = mem_sh;
          3'b010: dec.access = mem_sw;
          default: dec.alu_cmd = alu_ill;
        endcase
      end
      op_branch: begin
        dec.op1       = rs1_data;
        dec.op2       = rs2_data;
        dec.pc_target = pc + imm_b;
        dec.is_jump   = 1'b1;
        dec.pc_sel    = pc_branch;
        case (f.funct3)
          3'b000: dec.alu_cmd = alu_eq;
          3'b001: dec.alu_cmd = alu_ne;
          3'b100: dec.alu_cmd = alu_lt;
          3'b101: dec.alu_cmd = alu_ge;
          3'b110: dec.alu_cmd = alu_ltu;
          3'b111: dec.alu_cmd = alu_geu;
          default: ;
        endcase
      end
      op_lui, op_auipc: begin
        dec.alu_cmd = alu_add;
        dec.op1     = f.imm_u;
        dec.op2     = (f.opcode == op_auipc) ? pc : '0;
        dec.wb_sel  = ri_type_lui;
      end
      op_jal, op_jalr: begin
        // rd gets pc_plus_4, the alu result is not used
        dec.op1     = 32'd1;
        dec.wb_sel  = jump;
        dec.pc_sel  = pc_branch;
        dec.is_jump = 1'b1;
        if (f.opcode == op_jal) begin
          dec.alu_cmd   = alu_add;
          dec.pc_target = pc + imm_j;
        end else begin
          dec.pc_target = (rs1_data + imm_i) & ~32'd1;
          if (f.funct3 == 3'b000) dec.alu_cmd = alu_add;
        end
      end
      op_fence: begin
        // fence and fence.i run as nops
        if (f.funct3 == 3'b000 || f.funct3 == 3'b001) dec.alu_cmd = alu_add;
      end
      op_system: begin
        dec.csr      = 1'b1;
        dec.csr_addr = f.imm_i;
        dec.wb_sel   = zicsr;
        case (f.funct3)
          3'b001: begin
            dec.alu_cmd = alu_add;
            dec.op1     = rs1_data;
          end
          3'b010: begin
            dec.alu_cmd = alu_or;
            dec.op1     = csr_rdata;
            dec.op2     = rs1_data;
          end
          3'b011: begin
            dec.alu_cmd = alu_bit_c;
            dec.op1     = csr_rdata;
            dec.op2     = rs1_data;
          end
          3'b101: begin
            dec.alu_cmd = alu_add;
            dec.op1     = uimm;
          end
          3'b110: begin
            dec.alu_cmd = alu_or;
            dec.op1     = csr_rdata;
            dec.op2     = uimm;
          end
          3'b111: begin
            dec.alu_cmd = alu_bit_c;
            dec.op1     = csr_rdata;
            dec.op2     = uimm;
          end
          default: begin
            // privileged group, no csr access
            dec.csr      = 1'b0;
            dec.csr_addr = '0;
            dec.wb_sel   = wb_none;
            case (word)
              ecall_word: begin
                dec.alu_cmd  = alu_add;
                dec.env_call = 1'b1;
              end
              ebreak_word: begin
                dec.alu_cmd     = alu_add;
                dec.break_point = 1'b1;
              end
              mret_word: begin
                dec.alu_cmd  = alu_xor;
                dec.op1      = csr_rdata;
                dec.op2      = mret_mask;
                dec.csr_addr = mstatus_addr;
                dec.wb_sel   = wb_mret;
                dec.pc_sel   = pc_mret;
                dec.mret     = 1'b1;
              end
              default: ;
            endcase
          end
        endcase
      end
      default: ;
    endcase

    // unknown encodings carry nothing but the flag
    if (dec.alu_cmd == alu_ill) begin
      dec.op1       = '0;
      dec.op2       = '0;
      dec.wb_sel    = wb_none;
      dec.pc_sel    = pc_next;
      dec.pc_target = '0;
      dec.is_jump   = 1'b0;
    end
    // x0 destination drops the writeback, mret excepted
    if (f.rd == 5'd0 && !dec.mret) begin
      dec.wb_sel = wb_none;
    end
    dec.illegal = valid && (dec.alu_cmd == alu_ill);
  end
endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            wb_en,
  input  wire logic [4:0]      wb_addr,
  input  wire logic [xlen-1:0] wb_data,
  input  wire logic [4:0]      rs1_addr,
  input  wire logic [4:0]      rs2_addr,
  output logic [xlen-1:0]      rs1_data,
  output logic [xlen-1:0]      rs2_data
);
  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_addr != 5'd0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  req_ack_if.sink              pop,
  input  wire logic [xlen-1:0] csr_rdata,
  input  wire logic            wb_en,
  input  wire logic [4:0]      wb_addr,
  input  wire logic [xlen-1:0] wb_data,
  output logic                 out_req,
  input  wire logic            out_ack,
  output decoded_t             dec_out
);
  typedef enum logic [1:0] {
    st_idle,
    st_present,
    st_release
  } state_t;

  state_t          state;
  decoded_t        dec;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic            take;

  // head offered, output side free, last pop closed
  assign take = (state == st_idle) && pop.req && !pop.ack;

  instr_decoder u_decoder (
    .instr     (pop.entry.instr),
    .valid     (pop.req),
    .pc        (pop.entry.pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .csr_rdata (csr_rdata),
    .dec       (dec),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      pop.ack <= 1'b0;
      out_req <= 1'b0;
    end else begin
      if (take) begin
        pop.ack <= 1'b1;
      end else if (pop.ack && !pop.req) begin
        pop.ack <= 1'b0;
      end

      case (state)
        st_idle: begin
          if (take) state <= st_present;
        end
        st_present: begin
          // record loaded last cycle, now offer it
          if (!out_req) begin
            out_req <= 1'b1;
          end else if (out_ack) begin
            out_req <= 1'b0;
            state   <= st_release;
          end
        end
        st_release: begin
          if (!out_ack) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dec_out <= dec;
    end
  end

  a_out_req_held: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(out_req) |-> $past(out_ack)
  );
endmodule

`default_nettype wire

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top
  import core_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            in_req,
  output logic                 in_ack,
  input  wire logic [xlen-1:0] in_instr,
  input  wire logic [xlen-1:0] csr_rdata,
  input  wire logic            wb_en,
  input  wire logic [4:0]      wb_addr,
  input  wire logic [xlen-1:0] wb_data,
  output logic                 out_req,
  input  wire logic            out_ack,
  output decoded_t             dec_out
);
  // fetch port into queue, queue into decode
  req_ack_if push_if ();
  req_ack_if pop_if ();

  fetch_port u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_instr (in_instr),
    .push     (push_if.source)
  );

  fetch_queue u_queue (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (push_if.sink),
    .pop   (pop_if.source)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .pop       (pop_if.sink),
    .csr_rdata (csr_rdata),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .dec_out   (dec_out)
  );
endmodule

`default_nettype wire

// ==== verification/decode_model.svh ====
// next state of the 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected decoded record for one instruction word
function automatic decoded_t decode_ref(
  input logic [31:0] w,
  input logic [31:0] pc,
  input logic [31:0] regs [32],
  input logic [31:0] csr_val
);
  alu_cmd_t    r_ops [8];
  alu_cmd_t    br_ops [8];
  mem_access_t ld_ops [8];
  decoded_t    d;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] src;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        ok;

  // tables indexed by funct3
  r_ops  = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and};
  br_ops = '{alu_eq, alu_ne, alu_ill, alu_ill, alu_lt, alu_ge, alu_ltu, alu_geu};
  ld_ops = '{mem_lb, mem_lh, mem_lw, mem_none, mem_lbu, mem_lhu, mem_none, mem_none};

  a = regs[w[19:15]];
  b = regs[w[24:20]];
  f3 = w[14:12];
  f7 = w[31:25];
  imm_i = {{20{w[31]}}, w[31:20]};
  imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
  imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

  d = '0;
  d.alu_cmd = alu_ill;
  d.access = mem_none;
  d.wb_sel = wb_none;
  d.pc_sel = pc_next;
  d.rd = w[11:7];
  d.pc_plus_4 = pc + 32'd4;
  ok = 1'b0;

  case (w[6:0])
    op_r: begin
      // funct7 0x20 only for sub and sra
      ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      d.alu_cmd = (f7 == 7'h20) ? ((f3 == 3'd0) ? alu_sub : alu_sra) : r_ops[f3];
      d.op1 = a;
      d.op2 = b;
      d.wb_sel = ri_type_lui;
    end
    op_imm: begin
      if (f3 == 3'd1) begin
        ok = (f7 == 7'h00);
      end else if (f3 == 3'd5) begin
        ok = (f7 == 7'h00) || (f7 == 7'h20);
      end else begin
        ok = 1'b1;
      end
      d.alu_cmd = (f3 == 3'd5 && f7 == 7'h20) ? alu_sra : r_ops[f3];
      d.op1 = a;
      d.op2 = imm_i;
      d.wb_sel = ri_type_lui;
    end
    op_load: begin
      ok = (ld_ops[f3] != mem_none);
      d.alu_cmd = alu_add;
      d.access = ld_ops[f3];
      d.op1 = a;
      d.op2 = imm_i;
      d.wb_sel = load;
    end
    op_store: begin
      ok = (f3 < 3'd3);
      d.alu_cmd = alu_add;
      d.access = (f3 == 3'd0) ? mem_sb : (f3 == 3'd1) ? mem_sh : mem_sw;
      d.op1 = a;
      d.op2 = imm_s;
    end
    op_branch: begin
      ok = (br_ops[f3] != alu_ill);
      d.alu_cmd = br_ops[f3];
      d.op1 = a;
      d.op2 = b;
      d.pc_target = pc + imm_b;
      d.is_jump = 1'b1;
      d.pc_sel = pc_branch;
    end
    op_lui, op_auipc: begin
      ok = 1'b1;
      d.alu_cmd = alu_add;
      d.op1 = {w[31:12], 12'h000};
      d.op2 = (w[6:0] == op_auipc) ? pc : 32'd0;
      d.wb_sel = ri_type_lui;
    end
    op_jal, op_jalr: begin
      ok = (w[6:0] == op_jal) || (f3 == 3'd0);
      d.alu_cmd = alu_add;
      d.op1 = 32'd1;
      d.wb_sel = jump;
      d.pc_sel = pc_branch;
      d.is_jump = 1'b1;
      d.pc_target = (w[6:0] == op_jal) ? pc + imm_j : (a + imm_i) & 32'hffff_fffe;
    end
    op_fence: begin
      ok = (f3 <= 3'd1);
      d.alu_cmd = alu_add;
    end
    op_system: begin
      if (f3 != 3'd0 && f3 != 3'd4) begin
        ok = 1'b1;
        d.csr = 1'b1;
        d.csr_addr = w[31:20];
        d.wb_sel = zicsr;
        // immediate forms take the 5-bit rs1 field
        src = f3[2] ? {27'd0, w[19:15]} : a;
        case (f3[1:0])
          2'b01: begin
            d.alu_cmd = alu_add;
            d.op1 = src;
          end
          2'b10: begin
            d.alu_cmd = alu_or;
            d.op1 = csr_val;
            d.op2 = src;
          end
          default: begin
            d.alu_cmd = alu_bit_c;
            d.op1 = csr_val;
            d.op2 = src;
          end
        endcase
      end else begin
        case (w)
          32'h0000_0073: begin
            ok = 1'b1;
            d.alu_cmd = alu_add;
            d.env_call = 1'b1;
          end
          32'h0010_0073: begin
            ok = 1'b1;
            d.alu_cmd = alu_add;
            d.break_point = 1'b1;
          end
          32'h3020_0073: begin
            // mstatus with mie and mpie toggled
            ok = 1'b1;
            d.alu_cmd = alu_xor;
            d.op1 = csr_val;
            d.op2 = 32'h0000_0088;
            d.csr_addr = 12'h300;
            d.wb_sel = wb_mret;
            d.pc_sel = pc_mret;
            d.mret = 1'b1;
          end
          default: ok = 1'b0;
        endcase
      end
    end
    default: ok = 1'b0;
  endcase

  if (!ok) begin
    d = '0;
    d.alu_cmd = alu_ill;
    d.access = mem_none;
    d.wb_sel = wb_none;
    d.pc_sel = pc_next;
    d.rd = w[11:7];
    d.pc_plus_4 = pc + 32'd4;
    d.illegal = 1'b1;
  end else if (w[11:7] == 5'd0 && !d.mret) begin
    d.wb_sel = wb_none;
  end
  return d;
endfunction

// ==== verification/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb
  import core_pkg::*;
();
  localparam int num_instr = 300;
  localparam int batch_len = 20;
  localparam int num_batches = num_instr / batch_len;
  localparam int stall_batch = 2;
  localparam int blocked_cycles = 20;
  localparam int reset_cycles = 16;
  localparam int load_cycles = 64 + num_batches * 16;
  localparam int cycles_per_instr = 40;
  localparam int timeout_cycles = num_instr * cycles_per_instr + reset_cycles + load_cycles;

  logic        clk;
  logic        rst_n;
  logic        in_req;
  logic        in_ack;
  logic [31:0] in_instr;
  logic [31:0] csr_rdata;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        out_req;
  logic        out_ack;
  decoded_t    dec_out;

  logic [31:0] shadow [32];
  decoded_t    exp_q [$];
  int          sent_count;
  int          recv_count;
  logic        hold_out;
  logic [31:0] in_seed;
  logic [31:0] ack_seed;

`include "decode_model.svh"

  decode_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .in_instr  (in_instr),
    .csr_rdata (csr_rdata),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .dec_out   (dec_out)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input int idx,
                             input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch dec_out.%s in result %0d: got %h expected %h",
                         name, idx, got, exp));
    end
  endtask

  task automatic compare_decoded(input decoded_t got, input decoded_t exp, input int idx);
    check_field("alu_cmd", idx, 32'(got.alu_cmd), 32'(exp.alu_cmd));
    check_field("access", idx, 32'(got.access), 32'(exp.access));
    check_field("wb_sel", idx, 32'(got.wb_sel), 32'(exp.wb_sel));
    check_field("pc_sel", idx, 32'(got.pc_sel), 32'(exp.pc_sel));
    check_field("op1", idx, got.op1, exp.op1);
    check_field("op2", idx, got.op2, exp.op2);
    check_field("rd", idx, 32'(got.rd), 32'(exp.rd));
    check_field("csr_addr", idx, 32'(got.csr_addr), 32'(exp.csr_addr));
    check_field("pc_plus_4", idx, got.pc_plus_4, exp.pc_plus_4);
    check_field("pc_target", idx, got.pc_target, exp.pc_target);
    check_field("is_jump", idx, 32'(got.is_jump), 32'(exp.is_jump));
    check_field("illegal", idx, 32'(got.illegal), 32'(exp.illegal));
    check_field("env_call", idx, 32'(got.env_call), 32'(exp.env_call));
    check_field("break_point", idx, 32'(got.break_point), 32'(exp.break_point));
    check_field("mret", idx, 32'(got.mret), 32'(exp.mret));
    check_field("csr", idx, 32'(got.csr), 32'(exp.csr));
  endtask

  task automatic compare_count(input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("mismatch result count: got %h expected %h", got, exp));
    end
  endtask

  // two generator steps, upper halves only
  function automatic logic [31:0] next_rand();
    logic [31:0] hi;
    in_seed = lcg_next(in_seed);
    hi = in_seed;
    in_seed = lcg_next(in_seed);
    return {hi[31:16], in_seed[31:16]};
  endfunction

  // weighted mix of legal encodings and raw words
  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    logic [31:0] r;
    w = next_rand();
    r = next_rand();
    case (r[3:0])
      4'd0, 4'd1: begin
        w[6:0] = op_r;
        w[31:25] = r[4] ? 7'h20 : 7'h00;
      end
      4'd2, 4'd3: begin
        w[6:0] = op_imm;
        // shift amounts mostly with a legal funct7
        if (w[13:12] == 2'b01 && !r[5]) w[31:25] = r[4] ? 7'h20 : 7'h00;
      end
      4'd4: w[6:0] = op_load;
      4'd5: w[6:0] = op_store;
      4'd6, 4'd7: w[6:0] = op_branch;
      4'd8: w[6:0] = r[4] ? op_lui : op_auipc;
      4'd9: w[6:0] = op_jal;
      4'd10: begin
        w[6:0] = op_jalr;
        if (!r[5]) w[14:12] = 3'b000;
      end
      4'd11: begin
        w[6:0] = op_fence;
        w[14] = 1'b0;
      end
      4'd12, 4'd13: begin
        w[6:0] = op_system;
        if (w[13:12] == 2'b00) w[13:12] = 2'b01;
      end
      4'd14: begin
        case (r[5:4])
          2'd0: w = 32'h0000_0073;
          2'd1: w = 32'h0010_0073;
          2'd2: w = 32'h3020_0073;
          default: w[6:0] = op_system;
        endcase
      end
      default: ;
    endcase
    return w;
  endfunction

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_en = 1'b1;
    wb_addr = addr;
    wb_data = data;
    if (addr != 5'd0) shadow[addr] = data;
    @(negedge clk);
    wb_en = 1'b0;
  endtask

  task automatic check_flight();
    if (sent_count - recv_count > queue_depth + 1) begin
      fail_run($sformatf("%0d words in flight, more than the queue and decode stage hold",
                         sent_count - recv_count));
    end
  endtask

  // one four-phase transfer; blocked > 0 expects in_ack held low that long
  task automatic send_instr(input logic [31:0] w, input int blocked);
    exp_q.push_back(decode_ref(w, reset_pc + 32'(sent_count) * 32'd4, shadow, csr_rdata));
    in_instr = w;
    in_req = 1'b1;
    repeat (blocked) begin
      @(negedge clk);
      if (in_ack) fail_run("in_ack rose while the fetch queue was full");
    end
    // output side released once the full queue has been seen
    if (blocked > 0) hold_out = 1'b0;
    @(negedge clk);
    while (!in_ack) @(negedge clk);
    sent_count++;
    check_flight();
    in_req = 1'b0;
    @(negedge clk);
    while (in_ack) @(negedge clk);
  endtask

  task automatic wait_empty();
    while (recv_count < sent_count || out_req || out_ack) @(negedge clk);
    @(negedge clk);
  endtask

  initial begin : stimulus
    rst_n = 1'b0;
    in_req = 1'b0;
    in_instr = '0;
    csr_rdata = '0;
    wb_en = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    out_ack = 1'b0;
    hold_out = 1'b0;
    sent_count = 0;
    recv_count = 0;
    in_seed = 32'd28;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (in_ack !== 1'b0 || out_req !== 1'b0) begin
      fail_run("in_ack or out_req not low after reset");
    end
    // x0 is written too and must stay zero
    for (int i = 0; i < 32; i++) begin
      write_reg(5'(i), next_rand());
    end
    csr_rdata = next_rand();
    for (int b = 0; b < num_batches; b++) begin
      if (b > 0) begin
        csr_rdata = next_rand();
        repeat (4) write_reg(5'(next_rand()), next_rand());
      end
      hold_out = (b == stall_batch);
      for (int i = 0; i < batch_len; i++) begin
        if (b == stall_batch && i == queue_depth + 1) begin
          send_instr(random_instr(), blocked_cycles);
        end else begin
          send_instr(random_instr(), 0);
        end
      end
      wait_empty();
    end
    // no stray results after the last one
    repeat (20) @(negedge clk);
    compare_count(recv_count, num_instr);
    $display("No errors");
    $finish;
  end

  initial begin : responder
    decoded_t exp;
    int       delay;
    ack_seed = 32'd28;
    forever begin
      @(negedge clk);
      if (rst_n && out_req) begin
        while (hold_out) @(negedge clk);
        ack_seed = lcg_next(ack_seed);
        delay = int'(ack_seed[18:16]);
        repeat (delay) begin
          @(negedge clk);
          if (!out_req) fail_run("out_req fell before out_ack rose");
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          compare_decoded(dec_out, exp, recv_count);
        end
        // surplus results only raise the count
        recv_count++;
        out_ack = 1'b1;
        @(negedge clk);
        while (out_req) @(negedge clk);
        out_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    fail_run($sformatf("timeout after %0d cycles with %0d of %0d results received",
                       timeout_cycles, recv_count, num_instr));
  end
endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verification
logic/core_pkg.sv
logic/req_ack_if.sv
logic/fetch_port.sv
logic/fetch_queue.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/decode_top.sv
verification/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module decode_tb \
  -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vdecode_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$log"; then
  exit 0
fi
echo "pass line missing from $log"
exit 1
